// ==== verif/psramTbInput.txt ====
# Columns: op (W write, R read, E echo read, I idle), address, data, expected, all hex
# I takes its cycle count in the data column; E drives LFSR data and expects it back
# After reset the RAM reset bit is set and init is not done
R 00000800 00000000 00000001
R 00000880 00000000 00000000
I 00000000 00000002 00000000
# Unknown offsets inside the block echo the write data
E 00000844 00000000 00000000
E 000008ff 00000000 00000000
E 00000801 00000000 00000000
I 00000000 00000001 00000000
# Other blocks echo too but never raise read valid
R 00000900 5a5a5a5a 5a5a5a5a
R 0000f800 a5a5a5a5 a5a5a5a5
# Writes that must leave the RAM reset bit alone
W 00000900 00000000 00000000
W 00000700 00000000 00000000
W 00000880 00000000 00000000
R 00000800 00000000 00000001
I 00000000 00000003 00000000
# Release, power-up wait, command pulse, recovery
W 00000800 fffffffe 00000000
I 00000000 0000001e 00000000
R 00000880 00000000 00000001
R 00000800 00000000 00000000
# Set again after done
W 00000800 00000001 00000000
I 00000000 00000003 00000000
R 00000880 00000000 00000000
R 00000800 00000000 00000001
# Release and set again during power-up
W 00000800 00000000 00000000
I 00000000 00000005 00000000
W 00000800 00000001 00000000
I 00000000 00000019 00000000
R 00000880 00000000 00000000
# Clear once more for a full sequence
W 00000800 00000000 00000000
I 00000000 0000001e 00000000
R 00000880 00000000 00000001
R 00000800 00000000 00000000
I 00000000 00000002 00000000

// ==== run.sh ====
#!/usr/bin/env bash
# Build the PSRAM subsystem testbench with Verilator and run it
# Exit status follows the testbench verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module psramSubsysTb \
	--Mdir obj_dir -o psramSim \
	&& simOut="$(./obj_dir/psramSim)" \
	|| { echo "Build or simulation run did not complete"; exit 1; }

echo "$simOut"

echo "$simOut" | grep -qx "Verification passed" \
	&& exit 0 \
	|| exit 1

// ==== vlog.f ====
hw/psramPkg.sv
hw/usiBusIf.sv
hw/psramCsr.sv
hw/psramInitSeq.sv
hw/psramSubsys.sv
verif/psramSubsysTb.sv

// ==== verif/psramSubsysTb.sv ====
// PSRAM subsystem testbench
// Replays bus records from a text file and checks against a cycle model of the sequencer
`timescale 1ns/10ps
`default_nettype none

module psramSubsysTb;

	// --------------------
	// DUT signals
	// --------------------
	logic iSysClk;
	logic rstN;
	logic [psramPkg::busDataBits-1:0] busWd;
	logic [psramPkg::busAdrsBits-1:0] busAdrs;
	logic busWcke;
	logic [psramPkg::busDataBits-1:0] busRd;
	logic busRed;
	logic psramRstN;
	logic psramResetCmd;
	logic psramInitDone;

	// Records from the stimulus file
	logic [7:0] opQ [$];
	logic [31:0] adrsQ [$];
	logic [31:0] dataQ [$];
	logic [31:0] expQ [$];

	int unsigned errCnt;
	int unsigned checkCnt;
	int unsigned cycleCnt;
	// Zero until the records are loaded
	int unsigned cycleLimit;
	logic [31:0] lfsr;

	// --------------------
	// Reference model
	// --------------------
	// RAM reset bit as software last wrote it
	logic mRamRst;
	// Device reset released
	logic mRel;
	// Edges since release, saturating
	int unsigned mCnt;
	logic mDone;
	// Read valid expected after the last edge
	logic mRed;

	psramSubsys DUT
	(
		.iSysClk(iSysClk),
		.rstN(rstN),
		.busWd(busWd),
		.busAdrs(busAdrs),
		.busWcke(busWcke),
		.busRd(busRd),
		.busRed(busRed),
		.psramRstN(psramRstN),
		.psramResetCmd(psramResetCmd),
		.psramInitDone(psramInitDone)
	);

	// 100 ns period
	always #50 iSysClk = ~iSysClk;

	// Watchdog on total cycles
	always @(posedge iSysClk)
	begin
		cycleCnt = cycleCnt + 1;
		if ((cycleLimit != 0) && (cycleCnt > cycleLimit))
		begin
			$display("Run timed out after %0d cycles", cycleCnt);
			$display("Verification failed");
			$finish;
		end
	end

	// One Galois step, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
		begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	// 32 steps, one bit taken per step
	task automatic randWord(output logic [31:0] w);
		int i;
		w = '0;
		for (i = 0; i < 32; i++)
		begin
			lfsr = lfsrNext(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	task automatic checkVal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCnt++;
		if (actual !== expected)
		begin
			errCnt++;
			$display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Advance the model by one rising edge, pre-edge values only
	task automatic updateModel(input logic [31:0] adrs, input logic [31:0] wd, input logic wcke);
		logic sel;
		sel = (adrs[15:8] == psramPkg::csrBlockAdrs);
		mRed = sel;
		if (mRamRst)
		begin
			// Held in reset, done dropped
			mRel = 1'b0;
			mCnt = 0;
			mDone = 1'b0;
		end
		else if (!mRel)
		begin
			mRel = 1'b1;
			mCnt = 0;
		end
		else
		begin
			if (mCnt < psramPkg::pwrUpCycles + psramPkg::rstRecCycles)
			begin
				mCnt++;
			end
			if (mCnt == psramPkg::pwrUpCycles + psramPkg::rstRecCycles)
			begin
				mDone = 1'b1;
			end
		end
		// Bit takes effect on this edge, seen by the sequencer on the next
		if (wcke && sel && (adrs[7:0] == psramPkg::regRamRstOfs))
		begin
			mRamRst = wd[0];
		end
	endtask

	task automatic checkOutputs();
		logic expCmd;
		// Pulse sits pwrUpCycles edges after release
		expCmd = mRel && (mCnt == psramPkg::pwrUpCycles);
		checkVal(32'(busRed), 32'(mRed), "read valid");
		checkVal(32'(psramRstN), 32'(mRel), "device reset pin");
		checkVal(32'(psramResetCmd), 32'(expCmd), "reset command pulse");
		checkVal(32'(psramInitDone), 32'(mDone), "init done");
	endtask

	// Drive at the falling edge, check at the next one
	task automatic runCycle(input logic [31:0] adrs, input logic [31:0] wd, input logic wcke);
		busAdrs = adrs;
		busWd = wd;
		busWcke = wcke;
		@(negedge iSysClk);
		updateModel(adrs, wd, wcke);
		checkOutputs();
	endtask

	// --------------------
	// Stimulus file
	// --------------------
	task automatic loadRecords(output bit ok);
		int fd;
		int n;
		int unsigned lim;
		string line;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		ok = 1'b0;
		lim = 2 + psramPkg::pwrUpCycles + psramPkg::rstRecCycles + 50;
		fd = $fopen("verif/psramTbInput.txt", "r");
		if (fd == 0)
		begin
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			// Skip comments and blank lines
			if ((line.len() < 2) || (line.getc(0) == "#"))
			begin
				continue;
			end
			n = $sscanf(line, "%c %h %h %h", op, a, d, e);
			if (n != 4)
			begin
				errCnt++;
				$display("Malformed stimulus line: %s", line);
			end
			else
			begin
				opQ.push_back(op);
				adrsQ.push_back(a);
				dataQ.push_back(d);
				expQ.push_back(e);
				lim += (op == "I") ? d : 32'd1;
			end
		end
		$fclose(fd);
		cycleLimit = lim;
		ok = (opQ.size() != 0);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		logic [31:0] rdData;
		int i;
		bit loaded;
		iSysClk = 1'b0;
		rstN = 1'b0;
		busWd = '0;
		busAdrs = '0;
		busWcke = 1'b0;
		errCnt = 0;
		checkCnt = 0;
		cycleCnt = 0;
		cycleLimit = 0;
		lfsr = 32'h8ca0;
		mRamRst = 1'b1;
		mRel = 1'b0;
		mCnt = 0;
		mDone = 1'b0;
		mRed = 1'b0;
		loadRecords(loaded);
		if (!loaded)
		begin
			$display("Could not read any records from verif/psramTbInput.txt");
			$display("Verification failed");
			$finish;
		end
		else
		begin
			repeat (2) @(posedge iSysClk);
			@(negedge iSysClk);
			// Reset values before release
			checkOutputs();
			checkVal(busRd, 32'h0, "read data after reset");
			rstN = 1'b1;
			for (i = 0; i < opQ.size(); i++)
			begin
				case (opQ[i])
					"W": runCycle(adrsQ[i], dataQ[i], 1'b1);
					"R":
					begin
						runCycle(adrsQ[i], dataQ[i], 1'b0);
						checkVal(busRd, expQ[i], "register read");
					end
					"E":
					begin
						// Unmapped offset hands back the write data
						randWord(rdData);
						runCycle(adrsQ[i], rdData, 1'b0);
						checkVal(busRd, rdData, "echo read");
					end
					"I": repeat (dataQ[i]) runCycle(32'h0, 32'h0, 1'b0);
					default:
					begin
						errCnt++;
						$display("Unknown operation code in stimulus record %0d", i);
					end
				endcase
			end
			$display("Checks run: %0d, errors: %0d", checkCnt, errCnt);
			if (errCnt == 0)
			begin
				$display("Verification passed");
			end
			else
			begin
				$display("Verification failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== hw/psramSubsys.sv ====
// PSRAM configuration subsystem top level
// Register bus into the CSR block, CSR block into the init sequencer
`timescale 1ns/10ps
`default_nettype none

module psramSubsys
(
	input wire logic iSysClk,
	input wire logic rstN,
	// --------------------
	// Register bus
	// --------------------
	input wire logic [psramPkg::busDataBits-1:0] busWd,
	input wire logic [psramPkg::busAdrsBits-1:0] busAdrs,
	input wire logic busWcke,
	output logic [psramPkg::busDataBits-1:0] busRd,
	output logic busRed,
	// --------------------
	// Device side
	// --------------------
	output logic psramRstN,
	output logic psramResetCmd,
	output logic psramInitDone
);

	// Internal bus bundle
	usiBusIf usiBus ();

	// Reset request, CSR to sequencer
	logic ramRst;
	// Init done, sequencer back to the CSR
	logic ramInit;

	// Master side driven straight from the pins
	assign usiBus.wd = busWd;
	assign usiBus.adrs = busAdrs;
	assign usiBus.wcke = busWcke;

	// Responses back out
	assign busRd = usiBus.rd;
	assign busRed = usiBus.red;

	// --------------------
	// CSR block
	// --------------------
	psramCsr csr
	(
		.iSysClk(iSysClk),
		.rstN(rstN),
		.bus(usiBus.slave),
		.ramRst(ramRst),
		.ramInit(ramInit)
	);

	// --------------------
	// Init sequencer
	// --------------------
	psramInitSeq initSeq
	(
		.iSysClk(iSysClk),
		.rstN(rstN),
		.ramRst(ramRst),
		.psramRstN(psramRstN),
		.resetCmd(psramResetCmd),
		.initDone(ramInit)
	);

	// Done flag also goes off chip
	assign psramInitDone = ramInit;

endmodule

`default_nettype wire

// ==== hw/psramInitSeq.sv ====
// PSRAM initialization sequencer
// Device reset, power-up wait, reset command pulse, recovery wait
`timescale 1ns/10ps
`default_nettype none

module psramInitSeq
(
	input wire logic iSysClk,
	input wire logic rstN,
	// Software reset request from the CSR block
	input wire logic ramRst,
	// Device reset pin low while held
	output logic psramRstN,
	// One-cycle reset command to the device
	output logic resetCmd,
	// Sequence complete
	output logic initDone
);

	// --------------------
	// State and counter
	// --------------------
	psramPkg::initSeqState state;
	psramPkg::initSeqState stateNext;

	// Shared down-counter for both wait intervals
	logic [psramPkg::seqCntBits-1:0] cnt;
	logic [psramPkg::seqCntBits-1:0] cntNext;
	// Counter minus one
	logic [psramPkg::seqCntBits-1:0] cntDec;

	// Counter reached the end of its interval
	logic cntZero;

	assign cntZero = (cnt == '0);
	assign cntDec = cnt - {{(psramPkg::seqCntBits-1){1'b0}}, 1'b1};

	// --------------------
	// Next state
	// --------------------
	always_comb
	begin
		stateNext = state;
		cntNext = cnt;
		if (ramRst)
		begin
			// Reset request wins from every state
			stateNext = psramPkg::Hold;
			cntNext = '0;
		end
		else
		begin
			unique case (state)
				psramPkg::Hold:
				begin
					// First edge with the bit clear
					stateNext = psramPkg::PowerUp;
					cntNext = psramPkg::pwrUpLoad;
				end
				psramPkg::PowerUp:
				begin
					if (cntZero)
					begin
						stateNext = psramPkg::ResetCmd;
						// Recovery count starts with the pulse
						cntNext = psramPkg::rstRecLoad;
					end
					else
					begin
						cntNext = cntDec;
					end
				end
				psramPkg::ResetCmd:
				begin
					// Pulse lasts one cycle
					stateNext = psramPkg::Recover;
					if (!cntZero)
					begin
						cntNext = cntDec;
					end
				end
				psramPkg::Recover:
				begin
					// Park at zero once counted out
					if (!cntZero)
					begin
						cntNext = cntDec;
					end
				end
				default:
				begin
					stateNext = psramPkg::Hold;
					cntNext = '0;
				end
			endcase
		end
	end

	// --------------------
	// Registers
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			state <= psramPkg::Hold;
			cnt <= '0;
		end
		else
		begin
			state <= stateNext;
			cnt <= cntNext;
		end
	end

	// Done rises on the edge after recovery counts out
	always_ff @(posedge iSysClk)
	begin
		if (!rstN || ramRst)
		begin
			initDone <= 1'b0;
		end
		else if ((state == psramPkg::Recover) && cntZero)
		begin
			initDone <= 1'b1;
		end
	end

	// --------------------
	// Device outputs
	// --------------------
	// Reset pin released everywhere except Hold
	assign psramRstN = (state != psramPkg::Hold);
	assign resetCmd = (state == psramPkg::ResetCmd);

endmodule

`default_nettype wire

// ==== hw/psramCsr.sv ====
// PSRAM CSR block
// RAM reset control bit and init-done status on the register bus
`timescale 1ns/10ps
`default_nettype none

module psramCsr
(
	input wire logic iSysClk,
	input wire logic rstN,
	// Register bus slave side
	usiBusIf.slave bus,
	// Software controlled RAM reset level
	output logic ramRst,
	// Init done level from the sequencer
	input wire logic ramInit
);

	// --------------------
	// Address decode
	// --------------------
	// High when bits 15..8 carry this block's select
	logic blockSel;
	// Low byte picks the register inside the block
	logic [7:0] regOfs;
	// Write strobe aimed at the RAM reset register
	logic rstWrite;

	// Registered copy of init done
	logic ramInitQ;

	always_comb
	begin
		blockSel = (bus.adrs[psramPkg::csrBlockBits+7:8] == psramPkg::csrBlockAdrs);
		regOfs = bus.adrs[7:0];
		// Only the RAM reset register is writable
		rstWrite = bus.wcke && blockSel && (regOfs == psramPkg::regRamRstOfs);
	end

	// --------------------
	// Control register
	// --------------------
	// Reset value 1 keeps the device held after power-on
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ramRst <= 1'b1;
		end
		else if (rstWrite)
		begin
			// Bit 0 only
			ramRst <= bus.wd[0];
		end
	end

	// --------------------
	// Status register
	// --------------------
	// One flop stage on the way in from the sequencer
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ramInitQ <= 1'b0;
		end
		else
		begin
			ramInitQ <= ramInit;
		end
	end

	// --------------------
	// Read path
	// --------------------
	// Data loads every cycle and is valid only for block hits
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			bus.rd <= '0;
			bus.red <= 1'b0;
		end
		else
		begin
			if (blockSel)
			begin
				unique case (regOfs)
					psramPkg::regRamRstOfs:
					begin
						bus.rd <= {{(psramPkg::busDataBits-1){1'b0}}, ramRst};
					end
					psramPkg::regRamInitOfs:
					begin
						bus.rd <= {{(psramPkg::busDataBits-1){1'b0}}, ramInitQ};
					end
					default:
					begin
						// Unknown offset echoes write data
						bus.rd <= bus.wd;
					end
				endcase
			end
			else
			begin
				// Other blocks echo write data too
				bus.rd <= bus.wd;
			end
			// Any cycle that selects the block counts as a read
			bus.red <= blockSel;
		end
	end

endmodule

`default_nettype wire

// ==== hw/usiBusIf.sv ====
// Internal register bus bundle
// Single-cycle strobe bus, no back-pressure
`timescale 1ns/10ps
`default_nettype none

interface usiBusIf;

	// --------------------
	// Request side
	// --------------------
	// Write data, also echoed on unmapped reads
	logic [psramPkg::busDataBits-1:0] wd;
	// Address, block select in bits 15..8
	logic [psramPkg::busAdrsBits-1:0] adrs;
	// Write strobe, one cycle per write
	logic wcke;

	// --------------------
	// Response side
	// --------------------
	// Read data, valid one edge after the request
	logic [psramPkg::busDataBits-1:0] rd;
	// Read valid pulse
	logic red;

	// Bus owner drives requests
	modport master
	(
		output wd,
		output adrs,
		output wcke,
		input rd,
		input red
	);

	// CSR block answers them
	modport slave
	(
		input wd,
		input adrs,
		input wcke,
		output rd,
		output red
	);

endinterface

`default_nettype wire

// ==== hw/psramPkg.sv ====
// PSRAM controller shared definitions
// Register bus widths, CSR map and init sequencer timing
`default_nettype none

package psramPkg;

	// --------------------
	// Register bus
	// --------------------
	// Full bus address width
	localparam int unsigned busAdrsBits = 32;
	// Read and write data word width
	localparam int unsigned busDataBits = 32;

	// --------------------
	// CSR map
	// --------------------
	// Block select field, address bits 15..8
	localparam int unsigned csrBlockBits = 8;
	// Select value of this CSR block
	localparam logic [csrBlockBits-1:0] csrBlockAdrs = 8'h08;
	// RAM reset, read/write, bit 0, resets to 1
	localparam logic [7:0] regRamRstOfs = 8'h00;
	// Init done status, read only, bit 0
	localparam logic [7:0] regRamInitOfs = 8'h80;

	// --------------------
	// Init sequencer timing
	// --------------------
	// Cycles from reset release to the reset command pulse
	localparam int unsigned pwrUpCycles = 16;
	// Cycles from the reset command pulse to init done
	localparam int unsigned rstRecCycles = 8;
	// Shared down-counter sized for the longer interval
	localparam int unsigned seqCntBits =
		$clog2((pwrUpCycles > rstRecCycles) ? pwrUpCycles : rstRecCycles);
	// Counter load values, one count per cycle spent waiting
	localparam logic [seqCntBits-1:0] pwrUpLoad = seqCntBits'(pwrUpCycles - 1);
	localparam logic [seqCntBits-1:0] rstRecLoad = seqCntBits'(rstRecCycles - 1);

	// Sequencer states
	typedef enum logic [1:0]
	{
		Hold,
		PowerUp,
		ResetCmd,
		Recover
	} initSeqState;

endpackage

`default_nettype wire
